//--- mipsCore.f
hw/mipsPkg.sv
hw/fetchStage.sv
hw/controller.sv
hw/regFile.sv
hw/executeStage.sv
hw/memStage.sv
hw/apbHostPort.sv
hw/mipsCore.sv
dv/mipsCore_chk.sv
dv/mipsCoreTb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f mipsCore.f --top-module mipsCoreTb -o simv \
    || { echo "build failed"; exit 1; }

out="$(./obj_dir/simv 2>&1)"
echo "$out"
echo "$out" | grep -qxF "Simulation finished: PASS" && exit 0 || exit 1

//--- dv/mipsCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCoreTb;
    localparam int TestCycles = 600;   // budget per test
    localparam int NumTests   = 5;
    localparam int MaxPolls   = 50;

    logic             clk;
    logic             rst;
    mipsPkg::apbReq_t apb;
    mipsPkg::word_t   prdata;
    logic             pready;
    logic             pslverr;

    int             errorCount = 0;
    int             testsRun = 0;
    int             testsFailed = 0;
    int             testStartErrors = 0;
    mipsPkg::word_t lcgState = 32'd79;
    mipsPkg::word_t prog [$];

    mipsCore #(.ImemWords(64), .DmemWords(64)) u_dut (
        .clk(clk), .rst(rst), .apb(apb), .prdata(prdata), .pready(pready),
        .pslverr(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(NumTests * TestCycles * 10 + 2000);
        $display("watchdog expired before the tests completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

    function automatic mipsPkg::word_t nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    function automatic mipsPkg::word_t rTypeWord(input logic [4:0] rs, input logic [4:0] rt,
                                                 input logic [4:0] rd, input logic [5:0] fn);
        return {mipsPkg::opRtype, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic mipsPkg::word_t iTypeWord(input logic [5:0] op, input logic [4:0] rs,
                                                 input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic mipsPkg::word_t jalWord(input mipsPkg::word_t target);
        return {mipsPkg::opJal, target[27:2]};
    endfunction

    function automatic mipsPkg::word_t selfBranch();
        return {mipsPkg::opBeq, 5'd0, 5'd0, 16'hFFFF};   // beq r0,r0,-1
    endfunction

    function automatic logic [11:0] imemAt(input int idx);
        return mipsPkg::imemBase + 12'(4 * idx);
    endfunction

    function automatic logic [11:0] dmemAt(input int idx);
        return mipsPkg::dmemBase + 12'(4 * idx);
    endfunction

    task automatic checkEq(input string name, input mipsPkg::word_t got,
                           input mipsPkg::word_t exp);
        assert (got == exp) else begin
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
            errorCount++;
        end
    endtask

    task automatic apbTransfer(input logic [11:0] addr, input logic write,
                               input mipsPkg::word_t wdata, output mipsPkg::word_t rdata,
                               output logic err);
        @(posedge clk);
        #1;
        apb.paddr   = addr;
        apb.pwrite  = write;
        apb.pwdata  = wdata;
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        @(posedge clk);
        #1;
        apb.penable = 1'b1;
        @(negedge clk);   // access phase settled
        assert (pready) else begin
            $display("no pready in the access phase at address 0x%03h", addr);
            errorCount++;
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        apb.psel    = 1'b0;
        apb.penable = 1'b0;
    endtask

    task automatic apbWrite(input logic [11:0] addr, input mipsPkg::word_t data,
                            input logic expErr);
        mipsPkg::word_t rdIgnored;
        logic           err;
        apbTransfer(addr, 1'b1, data, rdIgnored, err);
        checkEq("pslverr", 32'(err), 32'(expErr));
    endtask

    task automatic apbRead(input logic [11:0] addr, output mipsPkg::word_t data,
                           input logic expErr);
        logic err;
        apbTransfer(addr, 1'b0, 32'd0, data, err);
        checkEq("pslverr", 32'(err), 32'(expErr));
    endtask

    task automatic checkMem(input int idx, input mipsPkg::word_t exp);
        mipsPkg::word_t got;
        apbRead(dmemAt(idx), got, 1'b0);
        checkEq($sformatf("dmem[%0d]", idx), got, exp);
    endtask

    task automatic loadProgram();
        apbWrite(mipsPkg::ctrlAddr, 32'd0, 1'b0);   // stop first
        foreach (prog[i]) begin
            apbWrite(imemAt(i), prog[i], 1'b0);
        end
    endtask

    task automatic runToHalt();
        mipsPkg::word_t status;
        int             polls = 0;
        apbWrite(mipsPkg::ctrlAddr, 32'd1, 1'b0);
        do begin
            apbRead(mipsPkg::statusAddr, status, 1'b0);
            polls++;
        end while (!status[0] && polls < MaxPolls);
        assert (status[0]) else begin
            $display("core did not halt within %0d status polls", MaxPolls);
            errorCount++;
        end
    endtask

    task automatic finishTest(input string name);
        testsRun++;
        if (errorCount != testStartErrors) begin
            testsFailed++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: passed", name);
        end
        testStartErrors = errorCount;
    endtask

    task automatic testApbMap();
        mipsPkg::word_t a;
        mipsPkg::word_t b;
        mipsPkg::word_t rd;
        a = nextRand();
        b = nextRand();
        apbWrite(mipsPkg::ctrlAddr, 32'd0, 1'b0);
        apbWrite(imemAt(5), a, 1'b0);
        apbRead(imemAt(5), rd, 1'b0);
        checkEq("imem[5]", rd, a);
        apbWrite(dmemAt(3), b, 1'b0);
        apbRead(dmemAt(3), rd, 1'b0);
        checkEq("dmem[3]", rd, b);
        apbRead(12'h300, rd, 1'b1);   // unmapped
        apbWrite(12'h300, a, 1'b1);
        apbWrite(mipsPkg::statusAddr, 32'h3, 1'b1);
        apbRead(mipsPkg::statusAddr, rd, 1'b0);
        checkEq("status", rd, 32'h0);
        apbWrite(imemAt(0), selfBranch(), 1'b0);   // park core, run stays high
        apbWrite(mipsPkg::ctrlAddr, 32'd1, 1'b0);
        apbWrite(dmemAt(3), ~b, 1'b1);
        apbWrite(imemAt(5), ~a, 1'b1);
        apbRead(dmemAt(3), rd, 1'b0);
        checkEq("dmem[3]", rd, b);
        apbRead(imemAt(5), rd, 1'b0);
        checkEq("imem[5]", rd, a);
        apbWrite(mipsPkg::ctrlAddr, 32'd0, 1'b0);
        finishTest("apbMap");
    endtask

    task automatic testArithmetic();
        mipsPkg::word_t a;
        mipsPkg::word_t b;
        a = nextRand();
        b = nextRand();
        prog = {
            iTypeWord(mipsPkg::opLui, 5'd0, 5'd1, a[31:16]),
            iTypeWord(mipsPkg::opOri, 5'd1, 5'd1, a[15:0]),
            iTypeWord(mipsPkg::opLui, 5'd0, 5'd2, b[31:16]),
            iTypeWord(mipsPkg::opOri, 5'd2, 5'd2, b[15:0]),
            rTypeWord(5'd1, 5'd2, 5'd3, mipsPkg::fnAddu),
            rTypeWord(5'd1, 5'd2, 5'd4, mipsPkg::fnSubu),
            rTypeWord(5'd1, 5'd2, 5'd0, mipsPkg::fnAddu),   // r0 must stay 0
            iTypeWord(mipsPkg::opSw, 5'd0, 5'd3, 16'd0),
            iTypeWord(mipsPkg::opSw, 5'd0, 5'd4, 16'd4),
            iTypeWord(mipsPkg::opSw, 5'd0, 5'd0, 16'd8),
            selfBranch()
        };
        loadProgram();
        apbWrite(dmemAt(2), 32'hFFFF_FFFF, 1'b0);
        runToHalt();
        checkMem(0, a + b);
        checkMem(1, a - b);
        checkMem(2, 32'h0);
        finishTest("arithmetic");
    endtask

    task automatic testMemory();
        mipsPkg::word_t c;
        mipsPkg::word_t d;
        c = nextRand();
        d = nextRand();
        prog = {
            iTypeWord(mipsPkg::opLui, 5'd0, 5'd1, c[31:16]),
            iTypeWord(mipsPkg::opOri, 5'd1, 5'd1, c[15:0]),
            iTypeWord(mipsPkg::opOri, 5'd0, 5'd5, 16'h0040),   // base word 16
            iTypeWord(mipsPkg::opSw, 5'd5, 5'd1, 16'hFFF8),
            iTypeWord(mipsPkg::opLw, 5'd5, 5'd2, 16'hFFF8),
            iTypeWord(mipsPkg::opLw, 5'd5, 5'd3, 16'hFFFC),
            rTypeWord(5'd2, 5'd3, 5'd4, mipsPkg::fnAddu),
            iTypeWord(mipsPkg::opSw, 5'd5, 5'd4, 16'd0),
            selfBranch()
        };
        loadProgram();
        apbWrite(dmemAt(14), 32'd0, 1'b0);
        apbWrite(dmemAt(15), d, 1'b0);
        apbWrite(dmemAt(16), 32'd0, 1'b0);
        runToHalt();
        checkMem(14, c);
        checkMem(16, c + d);
        finishTest("memory");
    endtask

    task automatic testControlFlow();
        prog = {
            iTypeWord(mipsPkg::opOri, 5'd0, 5'd1, 16'd5),
            iTypeWord(mipsPkg::opOri, 5'd0, 5'd2, 16'd5),
            iTypeWord(mipsPkg::opOri, 5'd0, 5'd3, 16'd7),
            iTypeWord(mipsPkg::opBeq, 5'd1, 5'd2, 16'd2),      // taken, skips 4 and 5
            iTypeWord(mipsPkg::opOri, 5'd0, 5'd4, 16'h0BAD),
            iTypeWord(mipsPkg::opSw, 5'd0, 5'd4, 16'd0),
            iTypeWord(mipsPkg::opOri, 5'd0, 5'd4, 16'h0111),
            iTypeWord(mipsPkg::opSw, 5'd0, 5'd4, 16'd0),
            iTypeWord(mipsPkg::opBeq, 5'd1, 5'd3, 16'd2),      // not taken
            iTypeWord(mipsPkg::opOri, 5'd0, 5'd4, 16'h0222),
            iTypeWord(mipsPkg::opSw, 5'd0, 5'd4, 16'd4),
            jalWord(32'd56),                                   // call word 14
            iTypeWord(mipsPkg::opSw, 5'd0, 5'd31, 16'd8),
            selfBranch(),
            iTypeWord(mipsPkg::opOri, 5'd0, 5'd5, 16'h0333),
            iTypeWord(mipsPkg::opSw, 5'd0, 5'd5, 16'd12),
            rTypeWord(5'd31, 5'd0, 5'd0, mipsPkg::fnJr)
        };
        loadProgram();
        for (int i = 0; i < 4; i++) begin
            apbWrite(dmemAt(i), 32'd0, 1'b0);
        end
        runToHalt();
        checkMem(0, 32'h111);
        checkMem(1, 32'h222);
        checkMem(2, 32'd48);   // link is jal pc + 4
        checkMem(3, 32'h333);
        finishTest("controlFlow");
    endtask

    task automatic testHaltRestart();
        mipsPkg::word_t status;
        prog = {
            iTypeWord(mipsPkg::opLw, 5'd0, 5'd1, 16'h0020),
            iTypeWord(mipsPkg::opOri, 5'd0, 5'd2, 16'd1),
            rTypeWord(5'd1, 5'd2, 5'd1, mipsPkg::fnAddu),
            iTypeWord(mipsPkg::opSw, 5'd0, 5'd1, 16'h0020),
            selfBranch()
        };
        loadProgram();
        apbWrite(dmemAt(8), 32'd0, 1'b0);
        runToHalt();
        apbRead(mipsPkg::statusAddr, status, 1'b0);
        checkEq("status", status, 32'h1);
        checkMem(8, 32'd1);
        repeat (10) @(posedge clk);
        apbRead(mipsPkg::statusAddr, status, 1'b0);
        checkEq("status", status, 32'h1);
        checkMem(8, 32'd1);
        apbWrite(mipsPkg::ctrlAddr, 32'd0, 1'b0);
        apbRead(mipsPkg::statusAddr, status, 1'b0);
        checkEq("status", status, 32'h0);
        runToHalt();   // second run
        checkMem(8, 32'd2);
        apbWrite(mipsPkg::ctrlAddr, 32'd0, 1'b0);
        finishTest("haltRestart");
    endtask

    initial begin
        apb = '0;
        rst = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        testApbMap();
        testArithmetic();
        testMemory();
        testControlFlow();
        testHaltRestart();
        if (u_dut.u_chk.failCount != 0) begin
            $display("bound assertions failed %0d times", u_dut.u_chk.failCount);
            errorCount += int'(u_dut.u_chk.failCount);
        end
        $display("tests run %0d, tests failed %0d, check errors %0d",
                 testsRun, testsFailed, errorCount);
        if (errorCount == 0 && testsFailed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/mipsCore_chk.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCoreChk (
    input logic             clk,
    input logic             rst,
    input mipsPkg::apbReq_t apb,
    input logic             pready,
    input logic             run,
    input logic             halted,
    input logic             rfWe,
    input logic             dmWe,
    input mipsPkg::word_t   pc
);
    int unsigned failCount = 0;   // read by the testbench at the end

    readyAfterSetup: assert property (@(posedge clk) disable iff (rst)
        (apb.psel && !apb.penable) |=> (apb.penable && pready))
    else begin
        failCount++;
        $error("no pready in the APB access phase after setup");
    end

    quietWhenStopped: assert property (@(posedge clk) disable iff (rst)
        (!run || halted) |-> !(rfWe || dmWe))
    else begin
        failCount++;
        $error("write enable while the core is stopped or halted");
    end

    pcFrozenWhenHalted: assert property (@(posedge clk) disable iff (rst)
        (run && halted) |=> $stable(pc))
    else begin
        failCount++;
        $error("pc moved while halted");
    end

endmodule

bind mipsCore mipsCoreChk u_chk (
    .clk(clk), .rst(rst), .apb(apb), .pready(pready), .run(run),
    .halted(halted), .rfWe(u_rf.we), .dmWe(u_mem.we), .pc(pc)
);

`default_nettype wire

//--- hw/mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore #(
    parameter int ImemWords = 64,
    parameter int DmemWords = 64
) (
    input  logic             clk,
    input  logic             rst,
    input  mipsPkg::apbReq_t apb,
    output mipsPkg::word_t   prdata,
    output logic             pready,
    output logic             pslverr
);
    mipsPkg::word_t    instr;
    mipsPkg::ctrl_t    ctrl;
    mipsPkg::word_t    pc;
    mipsPkg::word_t    pcPlus4;
    mipsPkg::word_t    rsData;
    mipsPkg::word_t    rtData;
    mipsPkg::word_t    aluResult;
    mipsPkg::word_t    wbData;
    mipsPkg::regAddr_t wrAddr;
    mipsPkg::word_t    hostRdData;
    mipsPkg::word_t    hostWrData;
    logic [5:0]        hostAddr;
    logic              hostWe;
    logic              run;
    logic              halted;
    logic              commit;

    // destination field: rt, rd or r31
    assign wrAddr = (ctrl.wrSel == mipsPkg::rd) ? instr[15:11] :
                    (ctrl.wrSel == mipsPkg::ra) ? 5'd31 : instr[20:16];

    apbHostPort #(.ImemWords(ImemWords)) u_host (
        .clk(clk), .rst(rst), .apb(apb), .halted(halted), .pc(pc),
        .dmemRdData(hostRdData), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .run(run), .instr(instr), .dmemWe(hostWe),
        .dmemAddr(hostAddr), .dmemWrData(hostWrData)
    );

    fetchStage u_fetch (
        .clk(clk), .rst(rst), .run(run), .ctrl(ctrl), .imm16(instr[15:0]),
        .jIndex(instr[25:0]), .rsData(rsData), .rtData(rtData), .pc(pc),
        .pcPlus4(pcPlus4), .halted(halted), .commit(commit)
    );

    controller u_ctrl (.instr(instr), .ctrl(ctrl));

    regFile u_rf (
        .clk(clk), .rst(rst), .we(ctrl.rfWe & commit), .rsAddr(instr[25:21]),
        .rtAddr(instr[20:16]), .wrAddr(wrAddr), .wrData(wbData),
        .rsData(rsData), .rtData(rtData)
    );

    executeStage u_exec (
        .ctrl(ctrl), .rsData(rsData), .rtData(rtData), .imm16(instr[15:0]),
        .aluResult(aluResult)
    );

    memStage #(.DmemWords(DmemWords)) u_mem (
        .clk(clk), .we(ctrl.dmWe & commit), .addr(aluResult), .wrData(rtData),
        .wdSel(ctrl.wdSel), .aluResult(aluResult), .pcPlus4(pcPlus4),
        .hostWe(hostWe), .hostAddr(hostAddr), .hostWrData(hostWrData),
        .wbData(wbData), .hostRdData(hostRdData)
    );

endmodule

`default_nettype wire

//--- hw/apbHostPort.sv
`timescale 1ns/1ps
`default_nettype none

module apbHostPort #(
    parameter int ImemWords = 64
) (
    input  logic             clk,
    input  logic             rst,
    input  mipsPkg::apbReq_t apb,
    input  logic             halted,
    input  mipsPkg::word_t   pc,
    input  mipsPkg::word_t   dmemRdData,
    output mipsPkg::word_t   prdata,
    output logic             pready,
    output logic             pslverr,
    output logic             run,
    output mipsPkg::word_t   instr,
    output logic             dmemWe,
    output logic [5:0]       dmemAddr,
    output mipsPkg::word_t   dmemWrData
);
    localparam int IdxW = $clog2(ImemWords);

    mipsPkg::word_t  imem [ImemWords];
    logic [IdxW-1:0] hostIdx;
    logic            access;
    logic            hitImem;
    logic            hitDmem;
    logic            hitCtrl;
    logic            hitStatus;
    logic            err;
    logic            wrOk;

    assign access    = apb.psel & apb.penable;
    assign hostIdx   = apb.paddr[IdxW+1:2];
    assign hitImem   = (apb.paddr[11:8] == mipsPkg::imemBase[11:8]) &&
                       (apb.paddr[7:2] < ImemWords);
    assign hitDmem   = (apb.paddr[11:8] == mipsPkg::dmemBase[11:8]);
    assign hitCtrl   = (apb.paddr == mipsPkg::ctrlAddr);
    assign hitStatus = (apb.paddr == mipsPkg::statusAddr);

    // unmapped, memory write while running, or status write
    assign err = ~(hitImem | hitDmem | hitCtrl | hitStatus) |
                 (apb.pwrite & (hitImem | hitDmem) & run) |
                 (apb.pwrite & hitStatus);

    assign pready     = access;   // no wait states
    assign pslverr    = access & err;
    assign wrOk       = access & apb.pwrite & ~err;
    assign dmemWe     = wrOk & hitDmem;
    assign dmemAddr   = apb.paddr[7:2];
    assign dmemWrData = apb.pwdata;
    assign instr      = (pc < 32'(4 * ImemWords)) ? imem[pc[IdxW+1:2]] : '0;

    always_ff @(posedge clk) begin
        if (wrOk && hitImem) begin
            imem[hostIdx] <= apb.pwdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            run <= 1'b0;
        end else if (wrOk && hitCtrl) begin
            run <= apb.pwdata[0];
        end
    end

    always_comb begin
        prdata = '0;
        if (hitImem) begin
            prdata = imem[hostIdx];
        end else if (hitDmem) begin
            prdata = dmemRdData;
        end else if (hitCtrl) begin
            prdata = {31'd0, run};
        end else if (hitStatus) begin
            prdata = {30'd0, run & ~halted, halted};
        end
    end

endmodule

`default_nettype wire

//--- hw/memStage.sv
`timescale 1ns/1ps
`default_nettype none

module memStage #(
    parameter int DmemWords = 64
) (
    input  logic            clk,
    input  logic            we,
    input  mipsPkg::word_t  addr,
    input  mipsPkg::word_t  wrData,
    input  mipsPkg::wdSel_e wdSel,
    input  mipsPkg::word_t  aluResult,
    input  mipsPkg::word_t  pcPlus4,
    input  logic            hostWe,
    input  logic [5:0]      hostAddr,
    input  mipsPkg::word_t  hostWrData,
    output mipsPkg::word_t  wbData,
    output mipsPkg::word_t  hostRdData
);
    localparam int AddrW = $clog2(DmemWords);

    mipsPkg::word_t   dmem [DmemWords];
    logic [AddrW-1:0] coreIdx;
    logic [AddrW-1:0] hostIdx;
    mipsPkg::word_t   rdData;

    assign coreIdx    = addr[AddrW+1:2];   // wraps inside the array
    assign hostIdx    = AddrW'(hostAddr);
    assign rdData     = dmem[coreIdx];
    assign hostRdData = dmem[hostIdx];

    always_ff @(posedge clk) begin
        if (we) begin
            dmem[coreIdx] <= wrData;
        end else if (hostWe) begin   // only while stopped
            dmem[hostIdx] <= hostWrData;
        end
    end

    always_comb begin
        case (wdSel)
            mipsPkg::memData: wbData = rdData;
            mipsPkg::linkPc:  wbData = pcPlus4;
            default:          wbData = aluResult;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  mipsPkg::ctrl_t ctrl,
    input  mipsPkg::word_t rsData,
    input  mipsPkg::word_t rtData,
    input  logic [15:0]    imm16,
    output mipsPkg::word_t aluResult
);
    mipsPkg::word_t immExt;
    mipsPkg::word_t opA;
    mipsPkg::word_t opB;

    always_comb begin
        if (ctrl.extOp == mipsPkg::signExt) begin
            immExt = {{16{imm16[15]}}, imm16};
        end else begin
            immExt = {16'h0000, imm16};
        end
    end

    assign opA = rsData;   // A is always rs
    assign opB = ctrl.bSel ? immExt : rtData;

    always_comb begin
        case (ctrl.aluOp)
            mipsPkg::add: begin
                aluResult = opA + opB;   // wraps, no overflow trap
            end
            mipsPkg::sub: begin
                aluResult = opA - opB;
            end
            mipsPkg::bitOr: begin
                aluResult = opA | opB;
            end
            mipsPkg::luiB: begin
                aluResult = {imm16, 16'h0000};
            end
            mipsPkg::passA: begin
                aluResult = opA;
            end
            default: begin
                aluResult = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic              clk,
    input  logic              rst,
    input  logic              we,
    input  mipsPkg::regAddr_t rsAddr,
    input  mipsPkg::regAddr_t rtAddr,
    input  mipsPkg::regAddr_t wrAddr,
    input  mipsPkg::word_t    wrData,
    output mipsPkg::word_t    rsData,
    output mipsPkg::word_t    rtData
);
    mipsPkg::word_t regs [32];

    assign rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
    assign rtData = (rtAddr == '0) ? '0 : regs[rtAddr];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wrAddr != '0) begin  // r0 never written
            regs[wrAddr] <= wrData;
        end
    end

endmodule

`default_nettype wire

//--- hw/controller.sv
`timescale 1ns/1ps
`default_nettype none

module controller (
    input  mipsPkg::word_t instr,
    output mipsPkg::ctrl_t ctrl
);
    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        ctrl = '0;   // nop and unknown codes
        case (opcode)
            mipsPkg::opRtype: begin
                case (funct)
                    mipsPkg::fnAddu: begin
                        ctrl.wrSel = mipsPkg::rd;
                        ctrl.rfWe  = 1'b1;
                        ctrl.aluOp = mipsPkg::add;
                    end
                    mipsPkg::fnSubu: begin
                        ctrl.wrSel = mipsPkg::rd;
                        ctrl.rfWe  = 1'b1;
                        ctrl.aluOp = mipsPkg::sub;
                    end
                    mipsPkg::fnJr: begin
                        ctrl.npcOp = mipsPkg::register;
                        ctrl.aluOp = mipsPkg::passA;
                    end
                    default: ;
                endcase
            end
            mipsPkg::opOri: begin
                ctrl.rfWe  = 1'b1;
                ctrl.bSel  = 1'b1;
                ctrl.aluOp = mipsPkg::bitOr;   // zero extended
            end
            mipsPkg::opLw: begin
                ctrl.wdSel = mipsPkg::memData;
                ctrl.rfWe  = 1'b1;
                ctrl.extOp = mipsPkg::signExt;
                ctrl.bSel  = 1'b1;
                ctrl.aluOp = mipsPkg::add;
            end
            mipsPkg::opSw: begin
                ctrl.extOp = mipsPkg::signExt;
                ctrl.bSel  = 1'b1;
                ctrl.aluOp = mipsPkg::add;
                ctrl.dmWe  = 1'b1;
            end
            mipsPkg::opBeq: begin
                ctrl.npcOp = mipsPkg::branch;  // compare done in fetch
                ctrl.extOp = mipsPkg::signExt;
            end
            mipsPkg::opLui: begin
                ctrl.rfWe  = 1'b1;
                ctrl.bSel  = 1'b1;
                ctrl.aluOp = mipsPkg::luiB;
            end
            mipsPkg::opJal: begin
                ctrl.npcOp = mipsPkg::jump;
                ctrl.wrSel = mipsPkg::ra;
                ctrl.wdSel = mipsPkg::linkPc;
                ctrl.rfWe  = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage (
    input  logic            clk,
    input  logic            rst,
    input  logic            run,
    input  mipsPkg::ctrl_t  ctrl,
    input  logic [15:0]     imm16,
    input  logic [25:0]     jIndex,
    input  mipsPkg::word_t  rsData,
    input  mipsPkg::word_t  rtData,
    output mipsPkg::word_t  pc,
    output mipsPkg::word_t  pcPlus4,
    output logic            halted,
    output logic            commit
);
    mipsPkg::word_t npc;
    mipsPkg::word_t branchTarget;
    mipsPkg::word_t jumpTarget;
    logic           equal;

    assign commit       = run & ~halted;
    assign pcPlus4      = pc + 32'd4;
    assign equal        = (rsData == rtData);
    assign branchTarget = pcPlus4 + {{14{imm16[15]}}, imm16, 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], jIndex, 2'b00};

    always_comb begin
        case (ctrl.npcOp)
            mipsPkg::branch:   npc = equal ? branchTarget : pcPlus4;
            mipsPkg::jump:     npc = jumpTarget;
            mipsPkg::register: npc = rsData;
            default:           npc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || !run) begin   // stopped core waits at 0
            pc     <= '0;
            halted <= 1'b0;
        end else if (commit) begin
            pc <= npc;
            if (npc == pc) begin
                halted <= 1'b1;  // self loop
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/mipsPkg.sv
`default_nettype none

package mipsPkg;

    typedef logic [31:0] word_t;   // data, address or instruction
    typedef logic [4:0]  regAddr_t;

    typedef enum logic [1:0] {
        pcPlus4  = 2'd0,
        branch   = 2'd1,
        jump     = 2'd2,
        register = 2'd3    // jr
    } npcOp_e;

    typedef enum logic [1:0] {
        rt = 2'd0,
        rd = 2'd1,
        ra = 2'd2          // r31 for jal
    } wrSel_e;

    typedef enum logic [1:0] {
        aluResult = 2'd0,
        memData   = 2'd1,
        linkPc    = 2'd2
    } wdSel_e;

    typedef enum logic {
        zeroExt = 1'b0,
        signExt = 1'b1
    } extOp_e;

    typedef enum logic [2:0] {
        add   = 3'd0,
        sub   = 3'd1,
        bitOr = 3'd2,
        luiB  = 3'd3,
        passA = 3'd4
    } aluOp_e;

    typedef struct packed {
        npcOp_e npcOp;
        wrSel_e wrSel;
        wdSel_e wdSel;
        logic   rfWe;
        extOp_e extOp;
        logic   bSel;      // 1 selects the extended immediate
        aluOp_e aluOp;
        logic   dmWe;
    } ctrl_t;

    localparam logic [5:0] opRtype = 6'b000000;
    localparam logic [5:0] opOri   = 6'b001101;
    localparam logic [5:0] opLw    = 6'b100011;
    localparam logic [5:0] opSw    = 6'b101011;
    localparam logic [5:0] opBeq   = 6'b000100;
    localparam logic [5:0] opLui   = 6'b001111;
    localparam logic [5:0] opJal   = 6'b000011;

    localparam logic [5:0] fnAddu  = 6'b100001;
    localparam logic [5:0] fnSubu  = 6'b100011;
    localparam logic [5:0] fnJr    = 6'b001000;

    typedef struct packed {
        logic [11:0] paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        word_t       pwdata;
    } apbReq_t;

    localparam logic [11:0] imemBase   = 12'h000;
    localparam logic [11:0] dmemBase   = 12'h100;
    localparam logic [11:0] ctrlAddr   = 12'h200;  // bit 0 run
    localparam logic [11:0] statusAddr = 12'h204;  // bit 0 halted, bit 1 running

endpackage

`default_nettype wire
